//--- src/fc_pkg.sv
`default_nettype none

package fc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths

    localparam int POOL_CI   = 3;
    localparam int OF_BW     = 8;
    localparam int W_BW      = 8;
    localparam int MUL_BW    = OF_BW + W_BW;
    localparam int KSUM_BW   = MUL_BW + 2;
    localparam int ACC_BW    = 24;

    // Longest frame the score width can hold without overflow
    localparam int MAX_BEATS = 2 ** (ACC_BW - KSUM_BW);

    // Type of the size parameters set at the top level
    typedef int unsigned count_t;

    ////////////////////////////////////////////////////////////////////////////
    // Data types

    typedef logic signed [OF_BW-1:0]  feat_el_t;
    typedef logic signed [W_BW-1:0]   w_el_t;
    typedef logic signed [ACC_BW-1:0] acc_t;

    typedef feat_el_t [POOL_CI-1:0] feat_t;
    typedef w_el_t [POOL_CI-1:0]    wvec_t;

    typedef struct packed {
        logic valid;
        logic first;
        logic last;
    } beat_ctl_t;

    typedef struct packed {
        beat_ctl_t                 ctl;
        logic signed [KSUM_BW-1:0] sum;
    } kern_out_t;

endpackage

`default_nettype wire

//--- src/fc_weight_bank.sv
`timescale 1ns/10ps
`default_nettype none

module fc_weight_bank #(
    parameter fc_pkg::count_t NUM_OUT   = 4,
    parameter fc_pkg::count_t NUM_BEATS = 4
) (
    input  wire                          clk,
    input  wire                          reset_n,
    input  wire                          i_pool_valid,
    input  wire fc_pkg::feat_t           i_pool_data,
    input  wire                          i_wt_we,
    input  wire [$clog2(NUM_OUT)-1:0]    i_wt_neuron,
    input  wire [$clog2(NUM_BEATS)-1:0]  i_wt_beat,
    input  wire fc_pkg::wvec_t           i_wt_data,
    output fc_pkg::beat_ctl_t            o_beat_ctl,
    output fc_pkg::feat_t                o_feat,
    output fc_pkg::wvec_t [NUM_OUT-1:0]  o_weights
);
    import fc_pkg::*;

    localparam int BEAT_W = $clog2(NUM_BEATS);

    wvec_t             wmem [NUM_OUT][NUM_BEATS];
    logic [BEAT_W-1:0] beat_cnt;
    logic              beat_last;

    assign beat_last = (beat_cnt == BEAT_W'(NUM_BEATS - 1));

    // Weight register file, one vector per neuron and beat
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int n = 0; n < NUM_OUT; n++) begin
                for (int b = 0; b < NUM_BEATS; b++) begin
                    wmem[n][b] <= '0;
                end
            end
        end else if (i_wt_we) begin
            wmem[i_wt_neuron][i_wt_beat] <= i_wt_data;
        end
    end

    // Beat position inside the frame
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            beat_cnt <= '0;
        end else if (i_pool_valid) begin
            beat_cnt <= beat_last ? '0 : beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_beat_ctl <= '0;
        end else begin
            o_beat_ctl.valid <= i_pool_valid;
            o_beat_ctl.first <= i_pool_valid && (beat_cnt == '0);
            o_beat_ctl.last  <= i_pool_valid && beat_last;
        end
    end

    // Features and this beat's weights for every neuron
    always_ff @(posedge clk) begin
        if (i_pool_valid) begin
            o_feat <= i_pool_data;
            for (int n = 0; n < NUM_OUT; n++) begin
                o_weights[n] <= wmem[n][beat_cnt];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Weight update ordering

    a_wt_frame_idle: assert property (@(posedge clk) disable iff (!reset_n)
        i_wt_we |-> (beat_cnt == '0))
        else $error("fc_weight_bank: weight write in the middle of a frame");

    a_wt_no_beat: assert property (@(posedge clk) disable iff (!reset_n)
        !(i_wt_we && i_pool_valid))
        else $error("fc_weight_bank: weight write and beat in the same cycle");

    a_wt_range: assert property (@(posedge clk) disable iff (!reset_n)
        i_wt_we |-> (i_wt_neuron < NUM_OUT) && (i_wt_beat < NUM_BEATS))
        else $error("fc_weight_bank: weight write index out of range");

endmodule

`default_nettype wire

//--- src/fc_kernel.sv
`timescale 1ns/10ps
`default_nettype none

module fc_kernel (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire fc_pkg::beat_ctl_t   i_beat_ctl,
    input  wire fc_pkg::feat_t       i_feat,
    input  wire fc_pkg::wvec_t       i_weights,
    output fc_pkg::kern_out_t        o_result
);
    import fc_pkg::*;

    beat_ctl_t                 r_ctl_mul;
    beat_ctl_t                 r_ctl_sum;
    logic signed [MUL_BW-1:0]  mul   [POOL_CI];
    logic signed [MUL_BW-1:0]  r_mul [POOL_CI];
    logic signed [KSUM_BW-1:0] ksum;
    logic signed [KSUM_BW-1:0] r_ksum;

    // Flags ride along with the data through both stages
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_ctl_mul <= '0;
            r_ctl_sum <= '0;
        end else begin
            r_ctl_mul <= i_beat_ctl;
            r_ctl_sum <= r_ctl_mul;
        end
    end

    // Stage 1: per-channel signed products
    always_comb begin
        for (int c = 0; c < POOL_CI; c++) begin
            mul[c] = i_feat[c] * i_weights[c];
        end
    end

    always_ff @(posedge clk) begin
        if (i_beat_ctl.valid) begin
            r_mul <= mul;
        end
    end

    // Stage 2: channel sum
    always_comb begin
        ksum = '0;
        for (int c = 0; c < POOL_CI; c++) begin
            ksum = ksum + r_mul[c];
        end
    end

    always_ff @(posedge clk) begin
        if (r_ctl_mul.valid) begin
            r_ksum <= ksum;
        end
    end

    assign o_result = '{ctl: r_ctl_sum, sum: r_ksum};

endmodule

`default_nettype wire

//--- src/fc_accumulator.sv
`timescale 1ns/10ps
`default_nettype none

module fc_accumulator #(
    parameter fc_pkg::count_t NUM_OUT   = 4,
    parameter fc_pkg::count_t NUM_BEATS = 4
) (
    input  wire                              clk,
    input  wire                              reset_n,
    input  wire fc_pkg::kern_out_t [NUM_OUT-1:0] i_kern,
    output logic                             o_result_valid,
    output fc_pkg::acc_t [NUM_OUT-1:0]       o_scores,
    output logic [$clog2(NUM_OUT)-1:0]       o_class
);
    import fc_pkg::*;

    localparam int CLS_W = $clog2(NUM_OUT);

    beat_ctl_t          ctl;
    acc_t [NUM_OUT-1:0] run_sum;
    acc_t [NUM_OUT-1:0] run_nxt;
    logic               frame_done;
    logic [CLS_W-1:0]   best_idx;
    acc_t               best_val;

    // Score width only covers MAX_BEATS beats
    if (NUM_BEATS > MAX_BEATS) begin : g_beat_limit
        $error("fc_accumulator: NUM_BEATS exceeds the score width headroom");
    end

    // All kernels run in lockstep, kernel 0 speaks for them
    assign ctl = i_kern[0].ctl;

    ////////////////////////////////////////////////////////////////////////////
    // Frame accumulation

    always_comb begin
        for (int n = 0; n < NUM_OUT; n++) begin
            run_nxt[n] = ctl.first ? acc_t'(i_kern[n].sum)
                                   : run_sum[n] + acc_t'(i_kern[n].sum);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            run_sum <= '0;
        end else if (ctl.valid) begin
            run_sum <= run_nxt;
        end
    end

    // Totals are captured on the last beat
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_scores   <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= ctl.valid && ctl.last;
            if (ctl.valid && ctl.last) begin
                o_scores <= run_nxt;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Argmax, strict compare keeps the lowest index on a tie

    always_comb begin
        best_idx = '0;
        best_val = o_scores[0];
        for (int n = 1; n < NUM_OUT; n++) begin
            if (o_scores[n] > best_val) begin
                best_val = o_scores[n];
                best_idx = CLS_W'(n);
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_result_valid <= 1'b0;
            o_class        <= '0;
        end else begin
            o_result_valid <= frame_done;
            if (frame_done) begin
                o_class <= best_idx;
            end
        end
    end

    for (genvar n = 1; n < NUM_OUT; n++) begin : g_ctl_check
        a_ctl_agree: assert property (@(posedge clk) disable iff (!reset_n)
            i_kern[n].ctl == i_kern[0].ctl)
            else $error("fc_accumulator: kernel %0d control differs from kernel 0", n);
    end

endmodule

`default_nettype wire

//--- src/fc_top.sv
`timescale 1ns/10ps
`default_nettype none

module fc_top #(
    parameter fc_pkg::count_t NUM_OUT   = 4,
    parameter fc_pkg::count_t NUM_BEATS = 4
) (
    input  wire                          clk,
    input  wire                          reset_n,
    input  wire                          i_pool_valid,
    input  wire fc_pkg::feat_t           i_pool_data,
    input  wire                          i_wt_we,
    input  wire [$clog2(NUM_OUT)-1:0]    i_wt_neuron,
    input  wire [$clog2(NUM_BEATS)-1:0]  i_wt_beat,
    input  wire fc_pkg::wvec_t           i_wt_data,
    output logic                         o_result_valid,
    output fc_pkg::acc_t [NUM_OUT-1:0]   o_scores,
    output logic [$clog2(NUM_OUT)-1:0]   o_class
);
    import fc_pkg::*;

    wire beat_ctl_t               bank_ctl;
    wire feat_t                   bank_feat;
    wire wvec_t [NUM_OUT-1:0]     bank_weights;
    wire kern_out_t [NUM_OUT-1:0] kern_res;

    fc_weight_bank #(
        .NUM_OUT   (NUM_OUT),
        .NUM_BEATS (NUM_BEATS)
    ) bank_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_pool_valid (i_pool_valid),
        .i_pool_data  (i_pool_data),
        .i_wt_we      (i_wt_we),
        .i_wt_neuron  (i_wt_neuron),
        .i_wt_beat    (i_wt_beat),
        .i_wt_data    (i_wt_data),
        .o_beat_ctl   (bank_ctl),
        .o_feat       (bank_feat),
        .o_weights    (bank_weights)
    );

    // One dot-product kernel per output neuron
    for (genvar n = 0; n < NUM_OUT; n++) begin : g_kernel
        fc_kernel kernel_i (
            .clk        (clk),
            .reset_n    (reset_n),
            .i_beat_ctl (bank_ctl),
            .i_feat     (bank_feat),
            .i_weights  (bank_weights[n]),
            .o_result   (kern_res[n])
        );
    end

    fc_accumulator #(
        .NUM_OUT   (NUM_OUT),
        .NUM_BEATS (NUM_BEATS)
    ) acc_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_kern         (kern_res),
        .o_result_valid (o_result_valid),
        .o_scores       (o_scores),
        .o_class        (o_class)
    );

endmodule

`default_nettype wire

//--- verification/fc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fc_tb;
    import fc_pkg::*;

    localparam int NUM_OUT     = 4;
    localparam int NUM_BEATS   = 4;
    localparam int CLS_W       = $clog2(NUM_OUT);
    localparam int BEAT_W      = $clog2(NUM_BEATS);
    localparam int LATENCY     = 4;
    localparam int WAIT_CYCLES = 20;
    localparam int MAX_GAP     = 2;

    logic               clk = 1'b0;
    logic               reset_n;
    logic               pool_valid;
    feat_t              pool_data;
    logic               wt_we;
    logic [CLS_W-1:0]   wt_neuron;
    logic [BEAT_W-1:0]  wt_beat;
    wvec_t              wt_data;
    logic               result_valid;
    acc_t [NUM_OUT-1:0] scores;
    logic [CLS_W-1:0]   class_idx;

    int    seed = 32'h6bcdf42f;
    int    cyc_cnt = 0;
    int    value_errs = 0;
    int    timeout_errs = 0;
    int    other_errs = 0;
    bit    aborted = 1'b0;
    string test_name;
    int    vals [16];

    // Results seen on the output, and the sampling edge of each frame's last beat
    int res_score_q [$];
    int res_class_q [$];
    int res_cyc_q   [$];
    int frame_edge_q [$];

    fc_top #(
        .NUM_OUT   (NUM_OUT),
        .NUM_BEATS (NUM_BEATS)
    ) dut_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_pool_valid   (pool_valid),
        .i_pool_data    (pool_data),
        .i_wt_we        (wt_we),
        .i_wt_neuron    (wt_neuron),
        .i_wt_beat      (wt_beat),
        .i_wt_data      (wt_data),
        .o_result_valid (result_valid),
        .o_scores       (scores),
        .o_class        (class_idx)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
    end

    // Every result pulse, with the edge it rose on
    always @(negedge clk) begin
        if (reset_n && result_valid) begin
            for (int n = 0; n < NUM_OUT; n++) begin
                res_score_q.push_back(int'(scores[n]));
            end
            res_class_q.push_back(int'(class_idx));
            res_cyc_q.push_back(cyc_cnt);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    function automatic int pick_gap();
        int r;
        r = $random(seed);
        return int'($unsigned(r) % (MAX_GAP + 1));
    endfunction

    task automatic release_inputs();
        @(negedge clk);
        pool_valid = 1'b0;
        pool_data  = '0;
        wt_we      = 1'b0;
        wt_neuron  = '0;
        wt_beat    = '0;
        wt_data    = '0;
    endtask

    task automatic write_weight(input int neuron, input int beat,
                                input int w0, input int w1, input int w2);
        @(negedge clk);
        pool_valid = 1'b0;
        wt_we      = 1'b1;
        wt_neuron  = CLS_W'(neuron);
        wt_beat    = BEAT_W'(beat);
        wt_data[0] = W_BW'(w0);
        wt_data[1] = W_BW'(w1);
        wt_data[2] = W_BW'(w2);
    endtask

    // Features come from vals[1..], gap_cfg below zero means random gaps
    task automatic drive_frame(input int gap_cfg);
        int gap;
        for (int b = 0; b < NUM_BEATS; b++) begin
            @(negedge clk);
            wt_we      = 1'b0;
            pool_valid = 1'b1;
            for (int c = 0; c < POOL_CI; c++) begin
                pool_data[c] = OF_BW'(vals[1 + b * POOL_CI + c]);
            end
            if (b == NUM_BEATS - 1) begin
                frame_edge_q.push_back(cyc_cnt + 1);
            end else begin
                gap = (gap_cfg < 0) ? pick_gap() : gap_cfg;
                for (int g = 0; g < gap; g++) begin
                    @(negedge clk);
                    pool_valid = 1'b0;
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    task automatic check_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            assert (result_valid == 1'b0) else begin
                $display("[ERROR] %s: o_result_valid expected 0, actual %0d",
                         test_name, result_valid);
                value_errs++;
            end
            for (int n = 0; n < NUM_OUT; n++) begin
                assert (scores[n] == '0) else begin
                    $display("[ERROR] %s: score[%0d] expected 0, actual %0d",
                             test_name, n, scores[n]);
                    value_errs++;
                end
            end
        end
    endtask

    // Expected scores in vals[0..3], expected class in vals[4]
    task automatic check_result();
        int waited;
        int got;
        int edge_at;
        release_inputs();
        waited = 0;
        while (res_class_q.size() == 0 && waited < WAIT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (res_class_q.size() == 0) begin
            $display("%s: no result arrived within %0d cycles", test_name, WAIT_CYCLES);
            timeout_errs++;
            aborted = 1'b1;
        end else if (frame_edge_q.size() == 0) begin
            $display("%s: an expected result was given without a frame", test_name);
            other_errs++;
            aborted = 1'b1;
        end else begin
            for (int n = 0; n < NUM_OUT; n++) begin
                got = res_score_q.pop_front();
                assert (got == vals[n]) else begin
                    $display("[ERROR] %s: score[%0d] expected %0d, actual %0d",
                             test_name, n, vals[n], got);
                    value_errs++;
                end
            end
            got = res_class_q.pop_front();
            assert (got == vals[NUM_OUT]) else begin
                $display("[ERROR] %s: class expected %0d, actual %0d",
                         test_name, vals[NUM_OUT], got);
                value_errs++;
            end
            edge_at = frame_edge_q.pop_front();
            got = res_cyc_q.pop_front() - edge_at;
            assert (got == LATENCY) else begin
                $display("[ERROR] %s: latency expected %0d, actual %0d",
                         test_name, LATENCY, got);
                value_errs++;
            end
        end
    endtask

    task automatic reject_line(input string line);
        $display("The tests file holds a line that cannot be read: %s", line);
        other_errs++;
        aborted = 1'b1;
    endtask

    task automatic finish_run();
        $display("Error counts: %0d value, %0d timeout, %0d other",
                 value_errs, timeout_errs, other_errs);
        if (value_errs + timeout_errs + other_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        string line;
        int    fd;
        int    n_read;
        byte   tag;
        reset_n    = 1'b0;
        pool_valid = 1'b0;
        pool_data  = '0;
        wt_we      = 1'b0;
        wt_neuron  = '0;
        wt_beat    = '0;
        wt_data    = '0;
        test_name  = "after_reset";
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        check_idle(8);

        fd = $fopen("verification/fc_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file verification/fc_tests.txt");
            other_errs++;
        end else begin
            while (!aborted && $fgets(line, fd) != 0) begin
                tag = line[0];
                case (tag)
                    "T": begin
                        n_read = $sscanf(line, "T %s", test_name);
                        if (n_read != 1) reject_line(line);
                    end
                    "W": begin
                        n_read = $sscanf(line, "W %d %d %d %d %d",
                                         vals[0], vals[1], vals[2], vals[3], vals[4]);
                        if (n_read != 5) begin
                            reject_line(line);
                        end else begin
                            write_weight(vals[0], vals[1], vals[2], vals[3], vals[4]);
                        end
                    end
                    "F": begin
                        n_read = $sscanf(line,
                            "F %d %d %d %d %d %d %d %d %d %d %d %d %d",
                            vals[0], vals[1], vals[2], vals[3], vals[4], vals[5], vals[6],
                            vals[7], vals[8], vals[9], vals[10], vals[11], vals[12]);
                        if (n_read != 13) begin
                            reject_line(line);
                        end else begin
                            drive_frame(vals[0]);
                        end
                    end
                    "E": begin
                        n_read = $sscanf(line, "E %d %d %d %d %d",
                                         vals[0], vals[1], vals[2], vals[3], vals[4]);
                        if (n_read != 5) begin
                            reject_line(line);
                        end else begin
                            check_result();
                        end
                    end
                    default: begin
                        // Comments and blank lines
                    end
                endcase
            end
            $fclose(fd);
        end

        release_inputs();
        repeat (10) @(negedge clk);
        assert (res_class_q.size() == 0) else begin
            $display("A result pulse arrived that no test expected");
            other_errs++;
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- verification/fc_tests.txt
# Columns per tag, values in decimal
# T name
# W neuron beat w0 w1 w2
# F gap f00 f01 f02 f10 f11 f12 f20 f21 f22 f30 f31 f32 (f beat channel, gap -1 is random)
# E score0 score1 score2 score3 class

T basic_dot
W 0 0 1 2 3
W 1 1 -1 -1 -1
W 2 2 2 0 -2
W 3 3 0 5 0
W 0 3 1 1 1
F 0 10 20 30 4 5 6 7 -3 1 -2 8 3
E 149 -15 12 40 0

T extremes
W 0 0 -128 -128 -128
W 1 0 127 127 127
W 2 0 -128 127 -128
F 1 -128 -128 -128 127 127 127 0 0 0 127 -128 127
E 49278 -49149 16512 -640 0

T tie_low_index
W 0 0 0 0 0
W 1 0 1 0 0
W 2 0 0 0 0
W 3 0 0 0 1
F 0 5 9 5 0 0 0 0 0 0 0 0 0
E 0 5 0 5 1

T back_to_back
F 0 3 0 0 1 2 3 4 0 1 1 1 1
F 0 0 0 7 0 0 0 -1 0 2 2 3 4
E 3 -3 6 5 2
E 9 0 -6 22 3

T random_gaps
F -1 -5 -5 -5 10 10 10 3 3 3 -1 -2 -3
E -6 -35 0 -15 2

T reload_weights
W 0 3 2 2 2
W 1 1 1 1 1
W 3 3 0 0 -4
F 0 -5 -5 -5 10 10 10 3 3 3 -1 -2 -3
E -12 25 0 7 1

//--- project.f
src/fc_pkg.sv
src/fc_weight_bank.sv
src/fc_kernel.sv
src/fc_accumulator.sv
src/fc_top.sv
verification/fc_tb.sv

//--- Bender.yml
package:
  name: fc_layer

sources:
  - src/fc_pkg.sv
  - src/fc_weight_bank.sv
  - src/fc_kernel.sv
  - src/fc_accumulator.sv
  - src/fc_top.sv
  - target: test
    files:
      - verification/fc_tb.sv
